//--- hw/subcarr_pkg.sv
// subcarrier control package: bus address map, data widths and reset timing constants

package subcarr_pkg;

  // ********************
  // bus and data widths
  // ********************

  // byte style address, bits 11 to 1 from the bus with bit 0 tied low
  localparam int ADDR_W = 12;

  // processor data bus
  localparam int DATA_W = 16;

  // one DAC sample, two's complement at the input
  localparam int DAC_W = 14;

  // per-lane source select
  localparam int DAC_SEL_W = 2;
  localparam int NUM_DAC   = 3;

  // ********************
  // address map
  // ********************

  // reads here fire the soft reset
  localparam logic [ADDR_W-1:0] ADDR_MISC_RESET = 12'h000;

  // version sits in the upper half, so read it with bit 1 set
  localparam logic [ADDR_W-1:0] ADDR_MISC_VERSION = 12'h004;

  // lane 0 select in the lowest pair
  localparam logic [ADDR_W-1:0] ADDR_DAC_IN_SEL = 12'h008;

  localparam logic [DATA_W-1:0] VER_NUMBER = 16'h0149;

  // ********************
  // source select codes
  // ********************

  // external word passes; codes 1 to 3 mute the lane
  localparam logic [DAC_SEL_W-1:0] DAC_SRC_EXT = 2'd0;

  // ********************
  // timing
  // ********************

  // cycles the DAC reset stays up after its trigger goes away
  localparam int RESET_STRETCH = 6;
  localparam int RST_CNT_W     = $clog2(RESET_STRETCH + 1);

  // flops in the bus strobe synchronizer
  localparam int SYNC_STAGES = 2;

endpackage

//--- hw/subcarr_regs.sv
// subcarrier register block: strobe sync, DAC select register, soft reset and read mux

`timescale 1ns/1ps

module subcarr_regs import subcarr_pkg::*; (
  input  logic                               ck933,
  input  logic                               rs,
  input  logic                               ncs_i,
  input  logic                               nrd_i,
  input  logic                               nwe_i,
  input  logic [ADDR_W-1:0]                  addr_i,
  input  logic [DATA_W-1:0]                  data_i,
  output logic [DATA_W-1:0]                  data_o,
  output logic                               data_oe_o,
  output logic [NUM_DAC-1:0][DAC_SEL_W-1:0]  dac_sel_o,
  output logic                               soft_rst_o
);

  // raw strobes, still asynchronous to ck933
  logic wr_req;
  logic rd_req;

  logic [SYNC_STAGES-1:0] wr_sync;
  logic [SYNC_STAGES-1:0] rd_sync;
  logic                   wr_last;
  logic                   rd_last;
  logic                   wr_fall;
  logic                   rd_rise;

  // bus word held from the strobe for the late commit
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] data_q;

  logic [ADDR_W-1:0]   word_addr;
  logic [2*DATA_W-1:0] top_dout;

  assign wr_req = !ncs_i && !nwe_i;
  assign rd_req = !ncs_i && !nrd_i;

  // bit 0 is not on the bus
  assign word_addr = {addr_i[ADDR_W-1:1], 1'b0};

  // ********************
  // strobe synchronizers
  // ********************

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      wr_sync <= '0;
      rd_sync <= '0;
      wr_last <= 1'b0;
      rd_last <= 1'b0;
    end else begin
      wr_sync <= {wr_sync[SYNC_STAGES-2:0], wr_req};
      rd_sync <= {rd_sync[SYNC_STAGES-2:0], rd_req};
      wr_last <= wr_sync[SYNC_STAGES-1];
      rd_last <= rd_sync[SYNC_STAGES-1];
    end
  end

  assign wr_fall = wr_last && !wr_sync[SYNC_STAGES-1];
  assign rd_rise = rd_sync[SYNC_STAGES-1] && !rd_last;

  // address and data are stable for the whole strobe, so grab them there
  always_ff @(posedge ck933) begin
    if (wr_req || rd_req) begin
      addr_q <= word_addr;
      data_q <= data_i;
    end
  end

  // ********************
  // register file
  // ********************

  // commit once the write strobe has ended, lower half only
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      dac_sel_o <= '0;
    end else if (wr_fall && !addr_q[1] &&
                 addr_q[ADDR_W-1:2] == ADDR_DAC_IN_SEL[ADDR_W-1:2]) begin
      dac_sel_o <= data_q[NUM_DAC*DAC_SEL_W-1:0];
    end
  end

  // one cycle pulse per read of the reset location
  assign soft_rst_o = rd_rise && addr_q[ADDR_W-1:2] == ADDR_MISC_RESET[ADDR_W-1:2];

  // ********************
  // read data
  // ********************

  // 32 bit view of the space, halves picked by bit 1
  always_comb begin
    top_dout = '0;
    if (word_addr[ADDR_W-1:2] == ADDR_MISC_VERSION[ADDR_W-1:2]) begin
      top_dout = {VER_NUMBER, {DATA_W{1'b0}}};
    end else if (word_addr[ADDR_W-1:2] == ADDR_DAC_IN_SEL[ADDR_W-1:2]) begin
      top_dout[NUM_DAC*DAC_SEL_W-1:0] = dac_sel_o;
    end
  end

  assign data_o    = word_addr[1] ? top_dout[2*DATA_W-1:DATA_W] : top_dout[DATA_W-1:0];
  assign data_oe_o = rd_req;

endmodule

//--- hw/dac_rst_gen.sv
// DAC reset generator: merges hard and soft reset and stretches the pulse

`timescale 1ns/1ps

module dac_rst_gen import subcarr_pkg::*; (
  input  logic ck933,
  input  logic rs,
  input  logic soft_rst_i,
  output logic dac_rst_o
);

  // cycles left before the DAC comes out of reset
  logic [RST_CNT_W-1:0] rst_cnt;

  // ********************
  // stretch counter
  // ********************

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      rst_cnt   <= RST_CNT_W'(RESET_STRETCH);
      dac_rst_o <= 1'b1;
    end else if (soft_rst_i) begin
      // restart the full stretch, even mid count
      rst_cnt   <= RST_CNT_W'(RESET_STRETCH);
      dac_rst_o <= 1'b1;
    end else if (rst_cnt != '0) begin
      rst_cnt   <= rst_cnt - 1'b1;
      // drop together with the last count
      dac_rst_o <= (rst_cnt != RST_CNT_W'(1));
    end else begin
      dac_rst_o <= 1'b0;
    end
  end

endmodule

//--- hw/dac_channel.sv
// DAC lane: reclocks the sample, applies the source select, drives offset binary to the pad

`timescale 1ns/1ps

module dac_channel import subcarr_pkg::*; (
  input  logic                 ck933,
  input  logic                 rs,
  input  logic [DAC_W-1:0]     dac_data_i,
  input  logic [DAC_SEL_W-1:0] sel_i,
  output logic [DAC_W-1:0]     dac_d_o
);

  logic [DAC_W-1:0] data_in_q;
  logic [DAC_W-1:0] data_sel_q;

  // ********************
  // input reclock
  // ********************

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      data_in_q <= '0;
    end else begin
      data_in_q <= dac_data_i;
    end
  end

  // only the external source is left, the other codes mute
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      data_sel_q <= '0;
    end else if (sel_i == DAC_SRC_EXT) begin
      data_sel_q <= data_in_q;
    end else begin
      data_sel_q <= '0;
    end
  end

  // ********************
  // pad register
  // ********************

  // flip the sign bit, two's complement to offset binary
  // reset value is mid scale
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      dac_d_o <= {1'b1, {(DAC_W-1){1'b0}}};
    end else begin
      dac_d_o <= {~data_sel_q[DAC_W-1], data_sel_q[DAC_W-2:0]};
    end
  end

endmodule

//--- hw/subcarr_top.sv
// subcarrier control top: register block, DAC reset generator, three DAC lanes, lock outputs

`timescale 1ns/1ps

module subcarr_top import subcarr_pkg::*; (
  input  logic              ck933,
  input  logic              rs,
  input  logic              ncs_i,
  input  logic              nrd_i,
  input  logic              nwe_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] data_i,
  input  logic [DAC_W-1:0]  dac0_data_i,
  input  logic [DAC_W-1:0]  dac1_data_i,
  input  logic [DAC_W-1:0]  dac2_data_i,
  input  logic              bsync_lock_i,
  input  logic              demod_lock_i,
  output logic [DATA_W-1:0] data_o,
  output logic              data_oe_o,
  output logic [DAC_W-1:0]  dac0_d_o,
  output logic [DAC_W-1:0]  dac1_d_o,
  output logic [DAC_W-1:0]  dac2_d_o,
  output logic              dac0_clk_o,
  output logic              dac1_clk_o,
  output logic              dac2_clk_o,
  output logic              dac_rst_o,
  output logic              bsync_nlock_o,
  output logic              demod_nlock_o
);

  logic [NUM_DAC-1:0][DAC_SEL_W-1:0] dac_sel;
  logic                              soft_rst;

  // ********************
  // processor registers
  // ********************

  subcarr_regs regs_i (
    .ck933      (ck933),
    .rs         (rs),
    .ncs_i      (ncs_i),
    .nrd_i      (nrd_i),
    .nwe_i      (nwe_i),
    .addr_i     (addr_i),
    .data_i     (data_i),
    .data_o     (data_o),
    .data_oe_o  (data_oe_o),
    .dac_sel_o  (dac_sel),
    .soft_rst_o (soft_rst)
  );

  dac_rst_gen rst_gen_i (
    .ck933      (ck933),
    .rs         (rs),
    .soft_rst_i (soft_rst),
    .dac_rst_o  (dac_rst_o)
  );

  // ********************
  // DAC lanes
  // ********************

  dac_channel dac0_i (
    .ck933(ck933), .rs(rs), .dac_data_i(dac0_data_i), .sel_i(dac_sel[0]), .dac_d_o(dac0_d_o)
  );

  dac_channel dac1_i (
    .ck933(ck933), .rs(rs), .dac_data_i(dac1_data_i), .sel_i(dac_sel[1]), .dac_d_o(dac1_d_o)
  );

  dac_channel dac2_i (
    .ck933(ck933), .rs(rs), .dac_data_i(dac2_data_i), .sel_i(dac_sel[2]), .dac_d_o(dac2_d_o)
  );

  // DACs latch on the system clock
  assign dac0_clk_o = ck933;
  assign dac1_clk_o = ck933;
  assign dac2_clk_o = ck933;

  // lock indicators go straight out
  assign bsync_nlock_o = bsync_lock_i;
  assign demod_nlock_o = demod_lock_i;

endmodule

//--- verif/tb_bus_tasks.svh
// processor bus helpers for the subcarrier testbench: write and read cycles, value check
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// compare one value and report the first wrong one
`define CHECK_EQ(name, got, exp) \
  assert ((got) === (exp)) else begin \
    report_mismatch(name, 32'(got), 32'(exp)); \
  end

// ********************
// bus cycles
// ********************

// strobe held two cycles before waiting out the synchronizer and the commit
task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
  @(posedge ck933);
  ncs_i  <= 1'b0;
  nwe_i  <= 1'b0;
  addr_i <= addr;
  data_i <= data;
  // no output enable during a write
  @(negedge ck933);
  `CHECK_EQ("data_oe_o", data_oe_o, 1'b0)
  repeat (2) @(posedge ck933);
  ncs_i <= 1'b1;
  nwe_i <= 1'b1;
  repeat (SYNC_STAGES + 2) @(posedge ck933);
endtask

// read data is combinational, so sample mid cycle while the strobe is low
task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
  @(posedge ck933);
  ncs_i  <= 1'b0;
  nrd_i  <= 1'b0;
  addr_i <= addr;
  @(negedge ck933);
  `CHECK_EQ("data_oe_o", data_oe_o, 1'b1)
  data = data_o;
  @(posedge ck933);
  ncs_i <= 1'b1;
  nrd_i <= 1'b1;
  @(negedge ck933);
  `CHECK_EQ("data_oe_o", data_oe_o, 1'b0)
endtask

`endif

//--- verif/tb_subcarr_top.sv
// testbench for the subcarrier control top: registers, DAC reset, lane routing and lock outputs

`timescale 1ns/1ps

module tb_subcarr_top import subcarr_pkg::*; ();

  localparam int NUM_ENTRIES = 8;
  localparam int WATCHDOG_NS = (NUM_ENTRIES + 20) * 10 * 100;
  localparam logic [DAC_W-1:0] MID_SCALE = 14'h2000;

  // lane 0 select in bits 1:0
  localparam logic [5:0] SEL_LIST [NUM_ENTRIES] = '{
    6'h00, 6'h01, 6'h0c, 6'h30, 6'h3f, 6'h24, 6'h12, 6'h39
  };

  typedef struct packed {
    logic [5:0]                    sel;
    logic [NUM_DAC-1:0][DAC_W-1:0] word;
    logic [NUM_DAC-1:0][DAC_W-1:0] pad;
    logic [1:0]                    lock;
  } stim_t;

  logic ck933;
  logic rs;
  logic ncs_i;
  logic nrd_i;
  logic nwe_i;
  logic [ADDR_W-1:0] addr_i;
  logic [DATA_W-1:0] data_i;
  logic [DAC_W-1:0]  dac0_data_i;
  logic [DAC_W-1:0]  dac1_data_i;
  logic [DAC_W-1:0]  dac2_data_i;
  logic bsync_lock_i;
  logic demod_lock_i;
  logic [DATA_W-1:0] data_o;
  logic data_oe_o;
  logic [DAC_W-1:0]  dac0_d_o;
  logic [DAC_W-1:0]  dac1_d_o;
  logic [DAC_W-1:0]  dac2_d_o;
  logic dac0_clk_o;
  logic dac1_clk_o;
  logic dac2_clk_o;
  logic dac_rst_o;
  logic bsync_nlock_o;
  logic demod_nlock_o;

  integer seed;
  stim_t  stim_tbl [NUM_ENTRIES];

  subcarr_top dut_i (.*);

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    report_failure($sformatf("MISMATCH %s got %0h expected %0h", name, got, exp));
  endtask

  `include "tb_bus_tasks.svh"

  // external source shows in offset binary and any other code sits at mid scale
  function automatic logic [DAC_W-1:0] expected_pad(input logic [DAC_SEL_W-1:0] code,
                                                    input logic [DAC_W-1:0] word);
    if (code == DAC_SRC_EXT) begin
      return word ^ MID_SCALE;
    end
    return MID_SCALE;
  endfunction

  // DAC clocks follow ck933 in both phases
  task automatic check_dac_clocks();
    @(posedge ck933);
    #25;
    `CHECK_EQ("dac0_clk_o", dac0_clk_o, 1'b1)
    `CHECK_EQ("dac1_clk_o", dac1_clk_o, 1'b1)
    `CHECK_EQ("dac2_clk_o", dac2_clk_o, 1'b1)
    @(negedge ck933);
    #25;
    `CHECK_EQ("dac0_clk_o", dac0_clk_o, 1'b0)
    `CHECK_EQ("dac1_clk_o", dac1_clk_o, 1'b0)
    `CHECK_EQ("dac2_clk_o", dac2_clk_o, 1'b0)
  endtask

  task automatic fill_table();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      stim_tbl[i].sel = SEL_LIST[i];
      for (int k = 0; k < NUM_DAC; k++) begin
        stim_tbl[i].word[k] = DAC_W'($random(seed));
        stim_tbl[i].pad[k]  = expected_pad(SEL_LIST[i][2*k +: 2], stim_tbl[i].word[k]);
      end
      // walk all four lock combinations
      stim_tbl[i].lock = 2'(i);
    end
  endtask

  initial begin
    ck933 = 1'b0;
    forever #50 ck933 = ~ck933;
  end

  initial begin
    #(WATCHDOG_NS);
    report_failure("watchdog expired before the test sequence finished");
  end

  initial begin
    logic [DATA_W-1:0] rd_data;
    logic [5:0]        last_sel;
    int                wait_cnt;
    seed = 32'h5aba_327b;
    fill_table();
    rs <= 1'b1;
    ncs_i <= 1'b1;
    nrd_i <= 1'b1;
    nwe_i <= 1'b1;
    addr_i <= '0;
    data_i <= '0;
    dac0_data_i <= '0;
    dac1_data_i <= '0;
    dac2_data_i <= '0;
    bsync_lock_i <= 1'b0;
    demod_lock_i <= 1'b0;

    // ********************
    // reset and stretch
    // ********************
    repeat (2) @(posedge ck933);
    @(negedge ck933);
    `CHECK_EQ("dac_rst_o", dac_rst_o, 1'b1)
    @(posedge ck933);
    rs <= 1'b0;
    repeat (RESET_STRETCH - 1) @(posedge ck933);
    @(negedge ck933);
    `CHECK_EQ("dac_rst_o", dac_rst_o, 1'b1)
    @(posedge ck933);
    @(negedge ck933);
    `CHECK_EQ("dac_rst_o", dac_rst_o, 1'b0)
    `CHECK_EQ("dac0_d_o", dac0_d_o, MID_SCALE)
    `CHECK_EQ("dac1_d_o", dac1_d_o, MID_SCALE)
    `CHECK_EQ("dac2_d_o", dac2_d_o, MID_SCALE)
    check_dac_clocks();
    bus_read(ADDR_DAC_IN_SEL, rd_data);
    `CHECK_EQ("data_o", rd_data, 16'h0000)

    // version sits in the upper half only
    bus_read(ADDR_MISC_VERSION | 12'h002, rd_data);
    `CHECK_EQ("data_o", rd_data, 16'h0149)
    bus_read(ADDR_MISC_VERSION, rd_data);
    `CHECK_EQ("data_o", rd_data, 16'h0000)

    // ********************
    // stimulus table
    // ********************
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      bus_write(ADDR_DAC_IN_SEL, DATA_W'(stim_tbl[i].sel));
      bus_read(ADDR_DAC_IN_SEL, rd_data);
      `CHECK_EQ("data_o", rd_data, DATA_W'(stim_tbl[i].sel))
      @(posedge ck933);
      dac0_data_i <= stim_tbl[i].word[0];
      dac1_data_i <= stim_tbl[i].word[1];
      dac2_data_i <= stim_tbl[i].word[2];
      bsync_lock_i <= stim_tbl[i].lock[0];
      demod_lock_i <= stim_tbl[i].lock[1];
      // input, select and pad registers
      repeat (3) @(posedge ck933);
      @(negedge ck933);
      `CHECK_EQ("dac0_d_o", dac0_d_o, stim_tbl[i].pad[0])
      `CHECK_EQ("dac1_d_o", dac1_d_o, stim_tbl[i].pad[1])
      `CHECK_EQ("dac2_d_o", dac2_d_o, stim_tbl[i].pad[2])
      `CHECK_EQ("bsync_nlock_o", bsync_nlock_o, stim_tbl[i].lock[0])
      `CHECK_EQ("demod_nlock_o", demod_nlock_o, stim_tbl[i].lock[1])
    end

    // upper half write must not touch the select register
    last_sel = stim_tbl[NUM_ENTRIES-1].sel;
    bus_write(ADDR_DAC_IN_SEL | 12'h002, DATA_W'(6'h3f ^ last_sel));
    bus_read(ADDR_DAC_IN_SEL, rd_data);
    `CHECK_EQ("data_o", rd_data, DATA_W'(last_sel))

    // ********************
    // soft reset
    // ********************
    bus_read(ADDR_MISC_RESET, rd_data);
    `CHECK_EQ("data_o", rd_data, 16'h0000)
    wait_cnt = 0;
    while (!dac_rst_o && wait_cnt < 8) begin
      @(negedge ck933);
      wait_cnt++;
    end
    assert (dac_rst_o) else begin
      report_failure("dac_rst_o never rose after reading the reset location");
    end
    wait_cnt = 0;
    while (dac_rst_o && wait_cnt <= RESET_STRETCH + 4) begin
      @(negedge ck933);
      wait_cnt++;
    end
    assert (!dac_rst_o) else begin
      report_failure("dac_rst_o stayed high too long after soft reset");
    end
    bus_read(ADDR_DAC_IN_SEL, rd_data);
    `CHECK_EQ("data_o", rd_data, DATA_W'(last_sel))

    $display("TB PASSED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+verif
hw/subcarr_pkg.sv
hw/subcarr_regs.sv
hw/dac_rst_gen.sv
hw/dac_channel.sv
hw/subcarr_top.sv
verif/tb_subcarr_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the subcarrier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_subcarr_top

status=0
./obj_dir/Vtb_subcarr_top > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "simulation reported a failure (exit status $status)"
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "simulation ended without a result (exit status $status)"
  exit 1
fi
echo "simulation clean"
